// ==== build.f ====
source/rv32_pkg.sv
source/rv32_if_stage.sv
source/rv32_id_stage.sv
source/rv32_regfile.sv
source/rv32_alu.sv
source/rv32_tracer.sv
source/rv32_core.sv
bench/tb_clock.sv
bench/tb_imem.sv
bench/tb_rv32_core.sv

// ==== Bender.yml ====
package:
  name: rv32_core

sources:
  - source/rv32_pkg.sv
  - source/rv32_if_stage.sv
  - source/rv32_id_stage.sv
  - source/rv32_regfile.sv
  - source/rv32_alu.sv
  - source/rv32_tracer.sv
  - source/rv32_core.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/tb_imem.sv
      - bench/tb_rv32_core.sv

// ==== bench/tb_rv32_core.sv ====
////////////////////////////////////////////////////////////
// Testbench top with DUT, memory model, reference model,
// trace and bus assertions, sleep phases and watchdog
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_rv32_core import rv32_pkg::*;;

  localparam logic [XLEN-1:0] BOOT_ADDR    = 32'h0000_1000;
  localparam int unsigned     CLK_PERIOD   = 40;
  localparam int unsigned     RESET_CYCLES = 16;
  localparam int unsigned     PROG_LEN     = 200;
  localparam int unsigned     MEM_WORDS    = 256;
  localparam int unsigned     SLEEP_LIMIT  = 40;
  localparam int unsigned     SLEEP_HOLD   = 8;
  localparam int unsigned     SLEEP_PHASES = 3;
  localparam int unsigned     TIMEOUT_NS   = (PROG_LEN * 10 + RESET_CYCLES +
                                            SLEEP_PHASES * (SLEEP_LIMIT + SLEEP_HOLD)) * CLK_PERIOD;

  logic clk, rst_ni, fetch_enable_i, core_sleep_o;
  logic [XLEN-1:0] boot_addr_i;
  logic instr_req_o, instr_gnt_i, instr_rvalid_i;
  logic [XLEN-1:0] instr_addr_o, instr_rdata_i;
  logic rvfi_valid_o, rvfi_trap_o;
  logic [63:0] rvfi_order_o;
  logic [XLEN-1:0] rvfi_insn_o, rvfi_pc_rdata_o, rvfi_pc_wdata_o;
  logic [XLEN-1:0] rvfi_rs1_rdata_o, rvfi_rs2_rdata_o, rvfi_rd_wdata_o;
  logic [REG_ADDR_W-1:0] rvfi_rd_addr_o;

  // Reference model state
  logic [XLEN-1:0] model_regs [32];
  logic [XLEN-1:0] exp_pc, exp_insn, exp_rs1, exp_rs2, exp_result;
  logic [63:0]     exp_order;
  logic            exp_legal, exp_writes;
  int              outst_cnt;

  tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_clock (.clk_o(clk));

  tb_imem #(.BOOT_ADDR(BOOT_ADDR), .MEM_WORDS(MEM_WORDS)) u_imem (
    .clk_i (clk), .rst_ni (rst_ni),
    .instr_req_i (instr_req_o), .instr_addr_i (instr_addr_o),
    .instr_gnt_o (instr_gnt_i), .instr_rvalid_o (instr_rvalid_i),
    .instr_rdata_o (instr_rdata_i),
    .peek_addr_i (exp_pc), .peek_data_o (exp_insn)
  );

  rv32_core #(.RV32E(1'b0)) dut (
    .clk (clk), .rst_ni (rst_ni), .boot_addr_i (boot_addr_i),
    .fetch_enable_i (fetch_enable_i),
    .instr_req_o (instr_req_o), .instr_gnt_i (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i), .instr_addr_o (instr_addr_o),
    .instr_rdata_i (instr_rdata_i), .core_sleep_o (core_sleep_o),
    .rvfi_valid_o (rvfi_valid_o), .rvfi_order_o (rvfi_order_o),
    .rvfi_insn_o (rvfi_insn_o), .rvfi_trap_o (rvfi_trap_o),
    .rvfi_pc_rdata_o (rvfi_pc_rdata_o), .rvfi_pc_wdata_o (rvfi_pc_wdata_o),
    .rvfi_rs1_rdata_o (rvfi_rs1_rdata_o), .rvfi_rs2_rdata_o (rvfi_rs2_rdata_o),
    .rvfi_rd_addr_o (rvfi_rd_addr_o), .rvfi_rd_wdata_o (rvfi_rd_wdata_o)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    report_failure($sformatf("[ERROR] %0t ns %s expected %0h actual %0h",
                             $time, name, expected, actual));
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic logic legal_insn(input logic [XLEN-1:0] insn);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = insn[14:12];
    f7 = insn[31:25];
    case (insn[6:0])
      OPCODE_LUI:    return 1'b1;
      OPCODE_OP_IMM: begin
        if (f3 == 3'b001) return f7 == 7'h00;
        if (f3 == 3'b101) return f7 == 7'h00 || f7 == 7'h20;
        return 1'b1;
      end
      OPCODE_OP:     return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
      default:       return 1'b0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] reference_result(input logic [XLEN-1:0] insn,
                                                      input logic [XLEN-1:0] a,
                                                      input logic [XLEN-1:0] rs2v);
    logic [XLEN-1:0] b;
    logic            reg_op;
    if (insn[6:0] == OPCODE_LUI) return {insn[31:12], 12'h000};
    reg_op = (insn[6:0] == OPCODE_OP);
    b      = reg_op ? rs2v : {{20{insn[31]}}, insn[31:20]};
    case (insn[14:12])
      3'b000:  return (reg_op && insn[30]) ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101: begin
        if (insn[30]) return $unsigned($signed(a) >>> b[4:0]);
        return a >> b[4:0];
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  always_comb begin
    exp_legal  = legal_insn(exp_insn);
    exp_rs1    = model_regs[exp_insn[19:15]];
    exp_rs2    = model_regs[exp_insn[24:20]];
    exp_result = reference_result(exp_insn, exp_rs1, exp_rs2);
    exp_writes = exp_legal && (exp_insn[11:7] != 5'd0);
  end

  always @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 32; i++) model_regs[i] <= '0;
      exp_pc    <= BOOT_ADDR;
      exp_order <= '0;
      outst_cnt <= 0;
    end else begin
      if (rvfi_valid_o) begin
        exp_pc    <= exp_pc + 32'd4;
        exp_order <= exp_order + 64'd1;
        if (exp_writes) model_regs[exp_insn[11:7]] <= exp_result;
      end
      if (instr_req_o && instr_gnt_i) outst_cnt <= outst_cnt + 1;
      else if (instr_rvalid_i) outst_cnt <= outst_cnt - 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  a_rd_wdata: assert property (@(posedge clk) disable iff (!rst_ni)
    rvfi_valid_o |-> rvfi_rd_wdata_o == (exp_writes ? exp_result : '0))
    else value_error("rvfi_rd_wdata_o", $sampled(exp_writes ? exp_result : '0),
                     $sampled(rvfi_rd_wdata_o));
  a_rd_addr: assert property (@(posedge clk) disable iff (!rst_ni)
    rvfi_valid_o |-> rvfi_rd_addr_o == (exp_writes ? exp_insn[11:7] : 5'd0))
    else value_error("rvfi_rd_addr_o", $sampled(exp_writes ? exp_insn[11:7] : 5'd0),
                     $sampled(rvfi_rd_addr_o));
  a_rs1: assert property (@(posedge clk) disable iff (!rst_ni)
    rvfi_valid_o |-> rvfi_rs1_rdata_o == exp_rs1)
    else value_error("rvfi_rs1_rdata_o", $sampled(exp_rs1), $sampled(rvfi_rs1_rdata_o));
  a_rs2: assert property (@(posedge clk) disable iff (!rst_ni)
    rvfi_valid_o |-> rvfi_rs2_rdata_o == exp_rs2)
    else value_error("rvfi_rs2_rdata_o", $sampled(exp_rs2), $sampled(rvfi_rs2_rdata_o));
  a_trap: assert property (@(posedge clk) disable iff (!rst_ni)
    rvfi_valid_o |-> rvfi_trap_o == !exp_legal)
    else value_error("rvfi_trap_o", $sampled(!exp_legal), $sampled(rvfi_trap_o));
  a_order: assert property (@(posedge clk) disable iff (!rst_ni)
    rvfi_valid_o |-> rvfi_order_o == exp_order)
    else value_error("rvfi_order_o", $sampled(exp_order), $sampled(rvfi_order_o));
  a_pc_rdata: assert property (@(posedge clk) disable iff (!rst_ni)
    rvfi_valid_o |-> rvfi_pc_rdata_o == exp_pc)
    else value_error("rvfi_pc_rdata_o", $sampled(exp_pc), $sampled(rvfi_pc_rdata_o));
  a_pc_wdata: assert property (@(posedge clk) disable iff (!rst_ni)
    rvfi_valid_o |-> rvfi_pc_wdata_o == exp_pc + 32'd4)
    else value_error("rvfi_pc_wdata_o", $sampled(exp_pc + 32'd4), $sampled(rvfi_pc_wdata_o));
  a_insn: assert property (@(posedge clk) disable iff (!rst_ni)
    rvfi_valid_o |-> rvfi_insn_o == exp_insn)
    else value_error("rvfi_insn_o", $sampled(exp_insn), $sampled(rvfi_insn_o));

  // Bus rule
  a_req_after_reset: assert property (@(posedge clk) $rose(rst_ni) |-> !instr_req_o)
    else report_failure("instr_req_o was high right after reset");
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else report_failure("instr_req_o or instr_addr_o changed before the grant");
  // No new request while a granted fetch waits for its rvalid
  a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_req_o |-> outst_cnt == 0)
    else value_error("outstanding grants", 64'd0, 64'($sampled(outst_cnt)));
  a_aligned: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_req_o |-> instr_addr_o[1:0] == 2'b00)
    else value_error("instr_addr_o[1:0]", 64'd0, 64'($sampled(instr_addr_o[1:0])));

  // Sleep
  a_sleep_quiet: assert property (@(posedge clk) disable iff (!rst_ni)
    core_sleep_o |-> !instr_req_o && !rvfi_valid_o)
    else report_failure("bus request or retirement while core_sleep_o was high");
  a_wake: assert property (@(posedge clk) disable iff (!rst_ni)
    $rose(fetch_enable_i) |=> !core_sleep_o)
    else report_failure("core_sleep_o stayed high after fetch_enable_i rose");

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic run_until(input int unsigned count);
    while (exp_order < 64'(count)) @(negedge clk);
  endtask

  task automatic wait_for_sleep();
    int unsigned cycles;
    cycles = 0;
    while (!core_sleep_o && cycles < SLEEP_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!core_sleep_o) report_failure("core_sleep_o did not rise after fetch_enable_i fell");
  endtask

  task automatic sleep_phase();
    fetch_enable_i = 1'b0;
    wait_for_sleep();
    repeat (SLEEP_HOLD) @(negedge clk);
    fetch_enable_i = 1'b1;
  endtask

  initial begin
    void'($urandom(32'hdb91));
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    u_imem.build_program();
    repeat (RESET_CYCLES) @(negedge clk);
    rst_ni = 1'b1;
    repeat (2) @(negedge clk);
    fetch_enable_i = 1'b1;
    run_until(PROG_LEN / 3);
    sleep_phase();
    run_until(2 * PROG_LEN / 3);
    sleep_phase();
    run_until(PROG_LEN);
    // Last phase drains the core and leaves it asleep
    fetch_enable_i = 1'b0;
    wait_for_sleep();
    repeat (4) @(negedge clk);
    $display("Test OK");
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    report_failure("Timeout: the program did not retire in time");
  end

endmodule

// ==== bench/tb_imem.sv ====
////////////////////////////////////////////////////////////
// Instruction memory model: random grant and rvalid delays,
// generated program and a second read port for the model
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_imem import rv32_pkg::*; #(
  parameter logic [XLEN-1:0] BOOT_ADDR = 32'h0000_1000,
  parameter int unsigned     MEM_WORDS = 256
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            instr_req_i,
  input  logic [XLEN-1:0] instr_addr_i,
  output logic            instr_gnt_o,
  output logic            instr_rvalid_o,
  output logic [XLEN-1:0] instr_rdata_o,
  input  logic [XLEN-1:0] peek_addr_i,
  output logic [XLEN-1:0] peek_data_o
);

  logic [XLEN-1:0] mem [MEM_WORDS];
  logic [XLEN-1:0] addr_q;
  logic            in_data;
  logic            granted;
  int unsigned     gnt_wait;
  int unsigned     rsp_wait;

  // Outside the program the bus returns an illegal word
  function automatic logic [XLEN-1:0] word_at(input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] index;
    index = (addr - BOOT_ADDR) >> 2;
    if (addr[1:0] == 2'b00 && index < MEM_WORDS) begin
      return mem[index];
    end
    return '0;
  endfunction

  // Mostly legal, with x0 writes and a few illegal words
  function automatic logic [XLEN-1:0] random_instr();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [31:0] rnd;
    int unsigned kind;
    rd   = 5'($urandom_range(0, 7));
    rs1  = 5'($urandom_range(0, 7));
    rs2  = 5'($urandom_range(0, 7));
    f3   = 3'($urandom);
    imm  = 12'($urandom);
    rnd  = $urandom;
    kind = $urandom_range(0, 9);
    case (kind)
      0: return {rnd[31:12], rd, OPCODE_LUI};
      1, 2, 3, 4: begin
        if (f3 == 3'b001) begin
          imm[11:5] = 7'h00;
        end else if (f3 == 3'b101) begin
          imm[11:5] = rnd[0] ? 7'h20 : 7'h00;
        end
        return {imm, rs1, f3, rd, OPCODE_OP_IMM};
      end
      5, 6, 7: begin
        f7 = (rnd[0] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
        return {f7, rs2, rs1, f3, rd, OPCODE_OP};
      end
      8: return {imm, rs1, 3'b000, 5'd0, OPCODE_OP_IMM};
      // M extension word or a load, both trap here
      default: return rnd[0] ? {7'h01, rs2, rs1, f3, rd, OPCODE_OP} : {rnd[31:7], 7'h03};
    endcase
  endfunction

  task automatic build_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = random_instr();
    end
  endtask

  initial begin
    instr_gnt_o    = 1'b0;
    instr_rvalid_o = 1'b0;
    instr_rdata_o  = '0;
    in_data        = 1'b0;
    gnt_wait       = 0;
    rsp_wait       = 0;
  end

  ////////////////////////////////////////////////////////////
  // Bus responder, driven on the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    // A grant seen at the last rising edge opened the data phase
    granted        = instr_gnt_o;
    instr_gnt_o    = 1'b0;
    instr_rvalid_o = 1'b0;
    if (!rst_ni) begin
      in_data  = 1'b0;
      gnt_wait = 1;
    end else if (granted || in_data) begin
      if (granted) begin
        rsp_wait = $urandom_range(0, 3);
      end
      if (rsp_wait == 0) begin
        instr_rvalid_o = 1'b1;
        instr_rdata_o  = word_at(addr_q);
        in_data        = 1'b0;
        gnt_wait       = $urandom_range(0, 3);
      end else begin
        rsp_wait = rsp_wait - 1;
        in_data  = 1'b1;
      end
    end else if (instr_req_i) begin
      if (gnt_wait == 0) begin
        instr_gnt_o = 1'b1;
        addr_q      = instr_addr_i;
      end else begin
        gnt_wait = gnt_wait - 1;
      end
    end
  end

  always_comb begin
    peek_data_o = word_at(peek_addr_i);
  end

endmodule

// ==== bench/tb_clock.sv ====
////////////////////////////////////////////////////////////
// Testbench clock generator
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_clock #(
  parameter int unsigned PERIOD_NS = 40
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// ==== source/rv32_core.sv ====
////////////////////////////////////////////////////////////
// RV32I core top level: fetch, decode/execute, register
// file, ALU and retirement trace
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rv32_core import rv32_pkg::*; #(
  parameter bit RV32E = 1'b0
) (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic [XLEN-1:0]       boot_addr_i,
  input  logic                  fetch_enable_i,
  output logic                  instr_req_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  output logic [XLEN-1:0]       instr_addr_o,
  input  logic [XLEN-1:0]       instr_rdata_i,
  output logic                  core_sleep_o,
  output logic                  rvfi_valid_o,
  output logic [63:0]           rvfi_order_o,
  output logic [XLEN-1:0]       rvfi_insn_o,
  output logic                  rvfi_trap_o,
  output logic [XLEN-1:0]       rvfi_pc_rdata_o,
  output logic [XLEN-1:0]       rvfi_pc_wdata_o,
  output logic [XLEN-1:0]       rvfi_rs1_rdata_o,
  output logic [XLEN-1:0]       rvfi_rs2_rdata_o,
  output logic [REG_ADDR_W-1:0] rvfi_rd_addr_o,
  output logic [XLEN-1:0]       rvfi_rd_wdata_o
);

  // IF/ID
  logic                  instr_valid;
  logic [XLEN-1:0]       instr_rdata;
  logic [XLEN-1:0]       pc_id;
  logic                  instr_ack;
  logic                  fetch_req;
  logic                  if_busy;
  // Register file and ALU
  logic [REG_ADDR_W-1:0] raddr_a;
  logic [REG_ADDR_W-1:0] raddr_b;
  logic [XLEN-1:0]       rdata_a;
  logic [XLEN-1:0]       rdata_b;
  logic                  we;
  logic [REG_ADDR_W-1:0] waddr;
  logic [XLEN-1:0]       wdata;
  alu_op_e               alu_op;
  logic [XLEN-1:0]       operand_a;
  logic [XLEN-1:0]       operand_b;
  logic [XLEN-1:0]       alu_result;
  // Retirement
  logic                  retire;
  logic                  trap;

  ////////////////////////////////////////////////////////////
  // Stages
  ////////////////////////////////////////////////////////////

  // Bus ports, clock and reset connect by name
  rv32_if_stage u_if_stage (
    .fetch_req_i   (fetch_req),
    .instr_valid_o (instr_valid), .instr_rdata_o (instr_rdata), .pc_id_o (pc_id),
    .instr_ack_i   (instr_ack),   .if_busy_o     (if_busy),
    .*
  );

  rv32_id_stage #(.RV32E(RV32E)) u_id_stage (
    .clk             (clk),          .rst_ni          (rst_ni),
    .fetch_enable_i  (fetch_enable_i),
    .instr_valid_i   (instr_valid),  .instr_rdata_i   (instr_rdata),
    .pc_id_i         (pc_id),        .instr_ack_o     (instr_ack),
    .if_busy_i       (if_busy),      .fetch_req_o     (fetch_req),
    .rf_raddr_a_o    (raddr_a),      .rf_raddr_b_o    (raddr_b),
    .rf_rdata_a_i    (rdata_a),      .rf_rdata_b_i    (rdata_b),
    .rf_we_o         (we),           .rf_waddr_o      (waddr),
    .rf_wdata_o      (wdata),        .alu_op_o        (alu_op),
    .alu_operand_a_o (operand_a),    .alu_operand_b_o (operand_b),
    .alu_result_i    (alu_result),   .retire_o        (retire),
    .trap_o          (trap),         .core_sleep_o    (core_sleep_o)
  );

  rv32_regfile #(.RV32E(RV32E)) u_regfile (
    .clk       (clk),     .rst_ni    (rst_ni),
    .raddr_a_i (raddr_a), .raddr_b_i (raddr_b),
    .rdata_a_o (rdata_a), .rdata_b_o (rdata_b),
    .we_i      (we),      .waddr_i   (waddr),   .wdata_i (wdata)
  );

  rv32_alu u_alu (
    .alu_op_i    (alu_op),    .operand_a_i (operand_a),
    .operand_b_i (operand_b), .result_o    (alu_result)
  );

  // Trace outputs connect by name to the top ports
  rv32_tracer u_tracer (
    .retire_i    (retire),  .trap_i      (trap),
    .insn_i      (instr_rdata), .pc_i    (pc_id),
    .rs1_rdata_i (rdata_a), .rs2_rdata_i (rdata_b),
    .rd_we_i     (we),      .rd_addr_i   (waddr),   .rd_wdata_i (wdata),
    .*
  );

endmodule

// ==== source/rv32_tracer.sv ====
////////////////////////////////////////////////////////////
// Retirement trace in RVFI style with the order counter
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rv32_tracer import rv32_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic                  retire_i,
  input  logic                  trap_i,
  input  logic [XLEN-1:0]       insn_i,
  input  logic [XLEN-1:0]       pc_i,
  input  logic [XLEN-1:0]       rs1_rdata_i,
  input  logic [XLEN-1:0]       rs2_rdata_i,
  input  logic                  rd_we_i,
  input  logic [REG_ADDR_W-1:0] rd_addr_i,
  input  logic [XLEN-1:0]       rd_wdata_i,
  output logic                  rvfi_valid_o,
  output logic [63:0]           rvfi_order_o,
  output logic [XLEN-1:0]       rvfi_insn_o,
  output logic                  rvfi_trap_o,
  output logic [XLEN-1:0]       rvfi_pc_rdata_o,
  output logic [XLEN-1:0]       rvfi_pc_wdata_o,
  output logic [XLEN-1:0]       rvfi_rs1_rdata_o,
  output logic [XLEN-1:0]       rvfi_rs2_rdata_o,
  output logic [REG_ADDR_W-1:0] rvfi_rd_addr_o,
  output logic [XLEN-1:0]       rvfi_rd_wdata_o
);

  logic rd_keep;

  // No write or a write to x0 shows up as rd = 0
  assign rd_keep = rd_we_i & (rd_addr_i != '0);

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rvfi_valid_o <= 1'b0;
      rvfi_trap_o  <= 1'b0;
      rvfi_order_o <= '0;
    end else begin
      rvfi_valid_o <= retire_i;
      rvfi_order_o <= rvfi_order_o + 64'(rvfi_valid_o);
      if (retire_i) begin
        rvfi_trap_o <= trap_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (retire_i) begin
      rvfi_insn_o      <= insn_i;
      rvfi_pc_rdata_o  <= pc_i;
      rvfi_pc_wdata_o  <= pc_i + XLEN'(4);
      rvfi_rs1_rdata_o <= rs1_rdata_i;
      rvfi_rs2_rdata_o <= rs2_rdata_i;
      rvfi_rd_addr_o   <= rd_keep ? rd_addr_i : '0;
      rvfi_rd_wdata_o  <= rd_keep ? rd_wdata_i : '0;
    end
  end

  a_order_step: assert property (@(posedge clk) disable iff (!rst_ni)
    !$stable(rvfi_order_o) |-> $past(rvfi_valid_o));

endmodule

// ==== source/rv32_alu.sv ====
////////////////////////////////////////////////////////////
// Integer ALU: add, subtract, compare, logic and shifts
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rv32_alu import rv32_pkg::*; (
  input  alu_op_e         alu_op_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  output logic [XLEN-1:0] result_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // Shift amount from the low bits of operand b
  assign shamt = operand_b_i[4:0];

  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;

  always_comb begin
    unique case (alu_op_i)
      ALU_ADD:  result_o = operand_a_i + operand_b_i;
      ALU_SUB:  result_o = operand_a_i - operand_b_i;
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_SLL:  result_o = operand_a_i << shamt;
      ALU_SRL:  result_o = operand_a_i >> shamt;
      ALU_SRA:  result_o = $unsigned($signed(operand_a_i) >>> shamt);
      default:  result_o = '0;
    endcase
  end

endmodule

// ==== source/rv32_regfile.sv ====
////////////////////////////////////////////////////////////
// Register file, two read ports and one write port
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rv32_regfile import rv32_pkg::*; #(
  parameter bit RV32E = 1'b0
) (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic [REG_ADDR_W-1:0] raddr_a_i,
  input  logic [REG_ADDR_W-1:0] raddr_b_i,
  output logic [XLEN-1:0]       rdata_a_o,
  output logic [XLEN-1:0]       rdata_b_o,
  input  logic                  we_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]       wdata_i
);

  localparam int unsigned NumRegs = RV32E ? 16 : 32;
  localparam int unsigned AddrW   = RV32E ? 4 : 5;

  logic [XLEN-1:0] regs_q [NumRegs];

  // x0 is never written and so reads zero
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i[AddrW-1:0]] <= wdata_i;
    end
  end

  assign rdata_a_o = regs_q[raddr_a_i[AddrW-1:0]];
  assign rdata_b_o = regs_q[raddr_b_i[AddrW-1:0]];

endmodule

// ==== source/rv32_id_stage.sv ====
////////////////////////////////////////////////////////////
// Decode and execute: decoder, operand and write-back
// select, controller FSM and the sleep output
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rv32_id_stage import rv32_pkg::*; #(
  parameter bit RV32E = 1'b0
) (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic                  fetch_enable_i,
  input  logic                  instr_valid_i,
  input  logic [XLEN-1:0]       instr_rdata_i,
  input  logic [XLEN-1:0]       pc_id_i,
  output logic                  instr_ack_o,
  input  logic                  if_busy_i,
  output logic                  fetch_req_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
  input  logic [XLEN-1:0]       rf_rdata_a_i,
  input  logic [XLEN-1:0]       rf_rdata_b_i,
  output logic                  rf_we_o,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output logic [XLEN-1:0]       rf_wdata_o,
  output alu_op_e               alu_op_o,
  output logic [XLEN-1:0]       alu_operand_a_o,
  output logic [XLEN-1:0]       alu_operand_b_o,
  input  logic [XLEN-1:0]       alu_result_i,
  output logic                  retire_o,
  output logic                  trap_o,
  output logic                  core_sleep_o
);

  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       imm_i;
  logic [XLEN-1:0]       imm_u;
  logic                  alt_op;
  logic                  legal;
  logic                  reg_bad;
  ctrl_state_e           state_q;
  ctrl_state_e           state_d;
  logic                  core_sleep_q;

  ////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////

  assign opcode = opcode_e'(instr_rdata_i[6:0]);
  assign rd     = instr_rdata_i[11:7];
  assign funct3 = instr_rdata_i[14:12];
  assign rs1    = instr_rdata_i[19:15];
  assign rs2    = instr_rdata_i[24:20];
  assign funct7 = instr_rdata_i[31:25];
  assign imm_i  = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign imm_u  = {instr_rdata_i[31:12], 12'b0};

  // SUB needs the OP group, SRA/SRAI exist in both
  assign alt_op = funct7[5] & ((opcode == OPCODE_OP) | (funct3 == 3'b101));

  always_comb begin
    legal   = 1'b0;
    reg_bad = 1'b0;
    case (opcode)
      OPCODE_LUI: begin
        legal   = 1'b1;
        reg_bad = RV32E & rd[4];
      end
      OPCODE_OP_IMM: begin
        legal = (funct3 == 3'b001) ? (funct7 == 7'h00) :
                (funct3 == 3'b101) ? (funct7 == 7'h00 || funct7 == 7'h20) : 1'b1;
        reg_bad = RV32E & (rd[4] | rs1[4]);
      end
      OPCODE_OP: begin
        legal = (funct7 == 7'h00) ||
                (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
        reg_bad = RV32E & (rd[4] | rs1[4] | rs2[4]);
      end
      default: legal = 1'b0;
    endcase
  end

  always_comb begin
    unique case (funct3)
      3'b000:  alu_op_o = alt_op ? ALU_SUB : ALU_ADD;
      3'b001:  alu_op_o = ALU_SLL;
      3'b010:  alu_op_o = ALU_SLT;
      3'b011:  alu_op_o = ALU_SLTU;
      3'b100:  alu_op_o = ALU_XOR;
      3'b101:  alu_op_o = alt_op ? ALU_SRA : ALU_SRL;
      3'b110:  alu_op_o = ALU_OR;
      default: alu_op_o = ALU_AND;
    endcase
  end

  // Operands and write-back, LUI bypasses the ALU
  assign rf_raddr_a_o    = rs1;
  assign rf_raddr_b_o    = rs2;
  assign alu_operand_a_o = rf_rdata_a_i;
  assign alu_operand_b_o = (opcode == OPCODE_OP) ? rf_rdata_b_i : imm_i;
  assign rf_waddr_o      = rd;
  assign rf_wdata_o      = (opcode == OPCODE_LUI) ? imm_u : alu_result_i;
  assign rf_we_o         = instr_valid_i & legal & ~reg_bad;

  // Every valid instruction executes in one cycle
  assign instr_ack_o = instr_valid_i;
  assign retire_o    = instr_valid_i;
  assign trap_o      = ~legal | reg_bad;

  ////////////////////////////////////////////////////////////
  // Controller
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_BOOT:  if (fetch_enable_i) state_d = CTRL_RUN;
      CTRL_RUN:   if (!fetch_enable_i) state_d = CTRL_DRAIN;
      CTRL_DRAIN: begin
        if (fetch_enable_i) begin
          state_d = CTRL_RUN;
        end else if (!if_busy_i && !instr_valid_i) begin
          state_d = CTRL_SLEEP;
        end
      end
      default:    if (fetch_enable_i) state_d = CTRL_RUN;
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= CTRL_BOOT;
      core_sleep_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      // Rises a cycle after entry, drops when leaving
      core_sleep_q <= (state_q == CTRL_SLEEP) && (state_d == CTRL_SLEEP);
    end
  end

  assign fetch_req_o  = (state_q == CTRL_RUN);
  assign core_sleep_o = core_sleep_q;

  a_retire_state: assert property (@(posedge clk) disable iff (!rst_ni)
    retire_o |-> instr_valid_i && (state_q inside {CTRL_RUN, CTRL_DRAIN}));

  a_sleep_idle: assert property (@(posedge clk) disable iff (!rst_ni)
    core_sleep_o |-> !if_busy_i && !instr_valid_i);

endmodule

// ==== source/rv32_if_stage.sv ====
////////////////////////////////////////////////////////////
// Instruction fetch: fetch PC, bus request with one request
// outstanding, and the IF/ID instruction register
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rv32_if_stage import rv32_pkg::*; (
  input  logic            clk,
  input  logic            rst_ni,
  input  logic [XLEN-1:0] boot_addr_i,
  input  logic            fetch_req_i,
  // Instruction bus
  output logic            instr_req_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic [XLEN-1:0] instr_rdata_i,
  // To ID stage
  output logic            instr_valid_o,
  output logic [XLEN-1:0] instr_rdata_o,
  output logic [XLEN-1:0] pc_id_o,
  input  logic            instr_ack_i,
  output logic            if_busy_o
);

  logic            req_q;
  logic            outst_q;
  logic            started_q;
  logic            instr_valid_q;
  logic [XLEN-1:0] fetch_pc_q;
  logic [XLEN-1:0] fetch_addr;
  logic [XLEN-1:0] instr_rdata_q;
  logic [XLEN-1:0] pc_id_q;
  logic            req_start;
  logic            gnt;

  // First fetch after reset goes to the boot address
  assign fetch_addr = started_q ? fetch_pc_q : boot_addr_i;

  // New request needs a free slot in the IF/ID register
  assign req_start = fetch_req_i & ~req_q & ~outst_q & (~instr_valid_q | instr_ack_i);

  assign instr_req_o  = req_q | req_start;
  assign instr_addr_o = fetch_addr;
  assign gnt          = instr_req_o & instr_gnt_i;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q         <= 1'b0;
      outst_q       <= 1'b0;
      started_q     <= 1'b0;
      instr_valid_q <= 1'b0;
      fetch_pc_q    <= '0;
    end else begin
      // Address phase stays open until granted
      req_q <= instr_req_o & ~instr_gnt_i;
      if (instr_rvalid_i) begin
        outst_q <= 1'b0;
      end
      if (gnt) begin
        outst_q    <= 1'b1;
        started_q  <= 1'b1;
        fetch_pc_q <= fetch_addr + XLEN'(4);
      end
      if (instr_rvalid_i) begin
        instr_valid_q <= 1'b1;
      end else if (instr_ack_i) begin
        instr_valid_q <= 1'b0;
      end
    end
  end

  // Fetch PC has already stepped past the word in flight
  always_ff @(posedge clk) begin
    if (instr_rvalid_i) begin
      instr_rdata_q <= instr_rdata_i;
      pc_id_q       <= fetch_pc_q - XLEN'(4);
    end
  end

  assign instr_valid_o = instr_valid_q;
  assign instr_rdata_o = instr_rdata_q;
  assign pc_id_o       = pc_id_q;
  assign if_busy_o     = instr_req_o | outst_q;

  // Bus rule checks
  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

  a_rvalid_outst: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_rvalid_i |-> outst_q);

endmodule

// ==== source/rv32_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared definitions of the RV32I core: widths, major
// opcodes, ALU operations and controller states
////////////////////////////////////////////////////////////

package rv32_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Data and address width
  localparam int unsigned XLEN = 32;

  // Register index width
  localparam int unsigned REG_ADDR_W = 5;

  ////////////////////////////////////////////////////////////
  // Major opcodes
  ////////////////////////////////////////////////////////////

  // Only these three groups are legal, anything else traps
  typedef enum logic [6:0] {
    OPCODE_OP_IMM = 7'h13,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37
  } opcode_e;

  ////////////////////////////////////////////////////////////
  // ALU operations
  ////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  // Controller states, SLEEP reports the core as idle
  typedef enum logic [1:0] {
    CTRL_BOOT,
    CTRL_RUN,
    CTRL_DRAIN,
    CTRL_SLEEP
  } ctrl_state_e;

endpackage
